// File: Makefile
VERILATOR ?= verilator
TOP       ?= inst_fetch_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/inst_fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module inst_fetch_tb;

    localparam int PROG_WORDS  = 1024;
    localparam int NUM_CHECKED = 3000;
    localparam int IDLE_LIMIT  = 400;
    localparam int EXCP_LIMIT  = 200;
    localparam int CYCLE_LIMIT = 200000;
    localparam fetch_pkg::addr_t REGION_END = `IMEM_MIN + 32'(PROG_WORDS * 4);

    logic                  clk;
    logic                  rst;
    logic                  flush_pc_branch;
    logic                  flush_pc_excp;
    logic                  flush_pc_ertn;
    logic                  stall_pc;
    logic                  flush_ififo;
    logic                  stall_ififo;
    logic                  jump;
    logic                  miss;
    logic                  full_ififo;
    logic                  ready_pc_out      [`DEC_WIDTH];
    fetch_pkg::addr_t      pc_out            [`DEC_WIDTH];
    fetch_pkg::inst_t      inst_out          [`DEC_WIDTH];
    logic                  is_branch_out     [`DEC_WIDTH];
    logic                  predict_out       [`DEC_WIDTH];
    fetch_pkg::addr_t      target_branch_out [`DEC_WIDTH];
    logic                  has_excp_out      [`DEC_WIDTH];
    fetch_pkg::excp_code_t excp_code_out     [`DEC_WIDTH];
    logic                  is_branch_rob;
    logic                  branch_rob;
    fetch_pkg::addr_t      target_rob;
    fetch_pkg::addr_t      pc_rob;
    fetch_pkg::addr_t      target_excp;
    fetch_pkg::addr_t      target_ertn;
    logic                  mem_rd_imem;
    fetch_pkg::addr_t      pc_imem;
    fetch_pkg::inst_t      inst              [`FETCH_WIDTH];
    logic                  find_inst         [`FETCH_WIDTH];

    // program image and the target of every word
    fetch_pkg::inst_t prog [PROG_WORDS];
    fetch_pkg::addr_t tgt  [PROG_WORDS];
    fetch_pkg::addr_t rob_q [$];

    fetch_pkg::addr_t exp_pc;
    logic             exp_known;
    logic             exp_excp;
    logic             waiting_excp;
    logic             need_recover;
    logic             held_valid;
    logic             held_ready [`DEC_WIDTH];
    fetch_pkg::addr_t held_pc    [`DEC_WIDTH];
    fetch_pkg::inst_t held_inst  [`DEC_WIDTH];
    int               delivered;
    int               idle_cycles;
    int               excp_wait;
    int               cycles;

    inst_fetch uut (.*);

    always #10 clk = ~clk;

    function automatic int word_index(input fetch_pkg::addr_t a);
        return int'(((a - `IMEM_MIN) >> 2) & 32'(PROG_WORDS - 1));
    endfunction

    function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t a);
        if (a >= `IMEM_MIN && a < REGION_END) begin
            return prog[word_index(a)];
        end
        // outside the image: plain word built from the address
        return {6'h00, a[27:2]};
    endfunction

    function automatic logic bad_addr(input fetch_pkg::addr_t a);
        return a < `IMEM_MIN || a > `IMEM_MAX || a[1:0] != 2'b00;
    endfunction

    function automatic fetch_pkg::addr_t good_target();
        return `IMEM_MIN + ($urandom_range(0, PROG_WORDS - 1) << 2);
    endfunction

    function automatic fetch_pkg::addr_t bad_target();
        case ($urandom_range(0, 2))
            0: return $urandom_range(0, 32'h0fff_ffff) & ~32'h3;
            1: return `IMEM_MAX + 32'd1 + ($urandom_range(0, 32'hff) << 4);
            default: return good_target() | 32'($urandom_range(1, 3));
        endcase
    endfunction

    // combinational instruction memory
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            inst[i] = mem_word({pc_imem[31:4], 2'(i), 2'b00});
        end
    end

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic fail_with(input string why);
        $display("%s at t=%0t", why, $time);
        abort_run();
    endtask

    task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_inst(input string name, input fetch_pkg::inst_t got,
                              input fetch_pkg::inst_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_code(input string name, input fetch_pkg::excp_code_t got,
                              input fetch_pkg::excp_code_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic build_program();
        int          t;
        int          r;
        logic [25:0] offs;
        for (int k = 0; k < PROG_WORDS; k++) begin
            r      = $urandom_range(0, 9);
            t      = $urandom_range(0, PROG_WORDS - 1);
            tgt[k] = good_target();
            if (r == 0 || k == PROG_WORDS - 1) begin
                // last word wraps back to the start
                if (k == PROG_WORDS - 1) begin
                    t = 0;
                end
                offs    = 26'(t - k);
                prog[k] = {6'($urandom_range(20, 21)), offs[15:0], offs[25:16]};
                tgt[k]  = `IMEM_MIN + 32'(t * 4);
            end else if (r < 3) begin
                prog[k] = {6'($urandom_range(22, 27)), 26'($urandom)};
            end else begin
                r       = $urandom_range(0, 55);
                prog[k] = {6'(r < 20 ? r : r + 8), 26'($urandom)};
            end
        end
    endtask

    task automatic consume_lane(input int j);
        fetch_pkg::addr_t lpc;
        fetch_pkg::inst_t w;
        logic             is_b;
        logic             is_br;
        lpc = pc_out[j];
        w   = inst_out[j];
        delivered++;
        idle_cycles = 0;
        if (exp_known) begin
            check_addr($sformatf("pc_out[%0d]", j), lpc, exp_pc);
        end
        if (exp_known && exp_excp) begin
            check_bit($sformatf("has_excp_out[%0d]", j), has_excp_out[j], 1'b1);
            check_code($sformatf("excp_code_out[%0d]", j), excp_code_out[j], `ADEF);
            // fetch keeps running past a bad address until the next flush
            exp_known    = 1'b0;
            waiting_excp = 1'b0;
            need_recover = 1'b1;
        end else if (!exp_known && has_excp_out[j]) begin
            check_code($sformatf("excp_code_out[%0d]", j), excp_code_out[j], `ADEF);
        end else begin
            check_bit($sformatf("has_excp_out[%0d]", j), has_excp_out[j], 1'b0);
            check_inst($sformatf("inst_out[%0d]", j), w, mem_word(lpc));
            is_b  = w[31:26] == 6'h14 || w[31:26] == 6'h15;
            is_br = w[31:26] >= 6'h14 && w[31:26] <= 6'h1b;
            check_bit($sformatf("is_branch_out[%0d]", j), is_branch_out[j], is_br);
            if (!is_br) begin
                check_bit($sformatf("predict_out[%0d]", j), predict_out[j], 1'b0);
            end
            if (exp_known) begin
                if (is_b || predict_out[j]) begin
                    check_addr($sformatf("target_branch_out[%0d]", j), target_branch_out[j],
                               tgt[word_index(lpc)]);
                    exp_pc = tgt[word_index(lpc)];
                end else begin
                    exp_pc = lpc + 32'd4;
                end
                // the odd plain word goes to the ROB too, a stale BTB entry
                if ((is_br && !is_b) || $urandom_range(0, 15) == 0) begin
                    rob_q.push_back(lpc);
                    if (rob_q.size() > 32) begin
                        void'(rob_q.pop_front());
                    end
                end
            end
        end
    endtask

    task automatic check_lanes();
        for (int j = 0; j + 1 < `DEC_WIDTH; j++) begin
            if (!ready_pc_out[j] && ready_pc_out[j + 1]) begin
                fail_with("ready lanes out of order");
            end
        end
        if (held_valid) begin
            for (int j = 0; j < `DEC_WIDTH; j++) begin
                if (held_ready[j]) begin
                    check_bit($sformatf("ready_pc_out[%0d]", j), ready_pc_out[j], 1'b1);
                    check_addr($sformatf("pc_out[%0d]", j), pc_out[j], held_pc[j]);
                    check_inst($sformatf("inst_out[%0d]", j), inst_out[j], held_inst[j]);
                end
            end
        end
        held_valid = 1'b0;
        // under flush_ififo the shown lanes are dropped
        if (!flush_ififo && stall_ififo) begin
            for (int j = 0; j < `DEC_WIDTH; j++) begin
                held_ready[j] = ready_pc_out[j];
                held_pc[j]    = pc_out[j];
                held_inst[j]  = inst_out[j];
            end
            held_valid = 1'b1;
        end else if (!flush_ififo) begin
            for (int j = 0; j < `DEC_WIDTH; j++) begin
                if (ready_pc_out[j]) begin
                    consume_lane(j);
                end
            end
        end
    endtask

    task automatic redirect(input fetch_pkg::addr_t t);
        case ($urandom_range(0, 2))
            0: begin
                flush_pc_excp <= 1'b1;
                target_excp   <= t;
            end
            1: begin
                flush_pc_ertn <= 1'b1;
                target_ertn   <= t;
            end
            default: begin
                flush_pc_branch <= 1'b1;
                target_rob      <= t;
            end
        endcase
        flush_ififo  <= 1'b1;
        exp_pc       = t;
        exp_known    = 1'b1;
        exp_excp     = bad_addr(t);
        waiting_excp = exp_excp;
        excp_wait    = 0;
    endtask

    task automatic drive_inputs();
        fetch_pkg::addr_t t;
        flush_pc_branch <= 1'b0;
        flush_pc_excp   <= 1'b0;
        flush_pc_ertn   <= 1'b0;
        flush_ififo     <= 1'b0;
        is_branch_rob   <= 1'b0;
        stall_ififo     <= $urandom_range(0, 3) == 0;
        stall_pc        <= $urandom_range(0, 7) == 0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            find_inst[i] <= $urandom_range(0, 15) != 0;
        end
        if (need_recover) begin
            need_recover = 1'b0;
            redirect(good_target());
        end else if (!waiting_excp && $urandom_range(0, 99) == 0) begin
            if ($urandom_range(0, 3) == 0) begin
                t = bad_target();
            end else begin
                t = good_target();
            end
            redirect(t);
        end else if (rob_q.size() > 0 && $urandom_range(0, 2) == 0) begin
            t = rob_q[$urandom_range(0, rob_q.size() - 1)];
            is_branch_rob <= 1'b1;
            branch_rob    <= $urandom_range(0, 3) != 0;
            pc_rob        <= t;
            target_rob    <= tgt[word_index(t)];
        end
    endtask

    initial begin
        void'($urandom(32'h32dc8267));
        clk             = 1'b0;
        rst             = 1'b1;
        flush_pc_branch = 1'b0;
        flush_pc_excp   = 1'b0;
        flush_pc_ertn   = 1'b0;
        stall_pc        = 1'b0;
        flush_ififo     = 1'b0;
        stall_ififo     = 1'b0;
        is_branch_rob   = 1'b0;
        branch_rob      = 1'b0;
        target_rob      = `IMEM_MIN;
        pc_rob          = `IMEM_MIN;
        target_excp     = `IMEM_MIN;
        target_ertn     = `IMEM_MIN;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            find_inst[i] = 1'b1;
        end
        exp_pc       = `IMEM_MIN;
        exp_known    = 1'b1;
        exp_excp     = 1'b0;
        waiting_excp = 1'b0;
        need_recover = 1'b0;
        held_valid   = 1'b0;
        delivered    = 0;
        idle_cycles  = 0;
        excp_wait    = 0;
        cycles       = 0;
        build_program();

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // state right after reset
        check_addr("pc_imem", pc_imem, `IMEM_MIN);
        check_bit("mem_rd_imem", mem_rd_imem, 1'b1);
        check_bit("jump", jump, 1'b0);
        check_bit("miss", miss, 1'b0);
        check_bit("full_ififo", full_ififo, 1'b0);
        for (int j = 0; j < `DEC_WIDTH; j++) begin
            check_bit($sformatf("ready_pc_out[%0d]", j), ready_pc_out[j], 1'b0);
        end

        while (delivered < NUM_CHECKED) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            // no memory read from a faulting base
            check_bit("mem_rd_imem", mem_rd_imem, !bad_addr(pc_imem));
            check_lanes();
            cycles++;
            idle_cycles++;
            if (waiting_excp) begin
                excp_wait++;
            end
            if (idle_cycles > IDLE_LIMIT) begin
                fail_with("no instruction delivered for too long");
            end
            if (waiting_excp && excp_wait > EXCP_LIMIT) begin
                fail_with("no fault lane after a redirect to a bad address");
            end
            if (cycles > CYCLE_LIMIT) begin
                fail_with("run exceeded its cycle budget");
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/branch_predictor.sv
logic/predecoder.sv
logic/inst_fifo.sv
logic/inst_fetch.sv
dv/inst_fetch_tb.sv

// File: logic/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module branch_predictor (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::addr_t pc,
    output logic             hit           [`FETCH_WIDTH],
    output logic             predict       [`FETCH_WIDTH],
    output fetch_pkg::addr_t target_branch [`FETCH_WIDTH],
    output fetch_pkg::addr_t target_first,
    output logic             predict_any,
    input  logic             is_branch_rob,
    input  logic             branch_rob,
    input  fetch_pkg::addr_t pc_rob,
    input  fetch_pkg::addr_t target_rob
);

    localparam int IDX_W = $clog2(`BTB_DEPTH);
    localparam int TAG_W = 30 - IDX_W;

    logic                btb_valid  [`BTB_DEPTH];
    logic [TAG_W-1:0]    btb_tag    [`BTB_DEPTH];
    fetch_pkg::addr_t    btb_target [`BTB_DEPTH];
    fetch_pkg::counter_t btb_cnt    [`BTB_DEPTH];

    logic [IDX_W-1:0]    upd_idx;
    logic                upd_hit;
    fetch_pkg::counter_t upd_cnt;

    assign upd_idx = pc_rob[IDX_W+1:2];
    assign upd_hit = btb_valid[upd_idx] && btb_tag[upd_idx] == pc_rob[31:IDX_W+2];
    assign upd_cnt = btb_cnt[upd_idx];

    // one lookup per slot, first live taken slot picks the next group
    always_comb begin
        logic [IDX_W-1:0] idx;
        fetch_pkg::addr_t spc;
        logic             found;
        found        = 1'b0;
        target_first = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            spc              = {pc[31:4], 2'(i), 2'b00};
            idx              = spc[IDX_W+1:2];
            hit[i]           = btb_valid[idx] && btb_tag[idx] == spc[31:IDX_W+2];
            predict[i]       = btb_cnt[idx][1];
            target_branch[i] = btb_target[idx];
            if (!found && 2'(i) >= pc[3:2] && hit[i] && predict[i]) begin
                found        = 1'b1;
                target_first = btb_target[idx];
            end
        end
        predict_any = found;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BTB_DEPTH; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else if (is_branch_rob && branch_rob) begin
            btb_valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (is_branch_rob && branch_rob) begin
            btb_tag[upd_idx]    <= pc_rob[31:IDX_W+2];
            btb_target[upd_idx] <= target_rob;
            // new entries start weakly taken
            if (!upd_hit) begin
                btb_cnt[upd_idx] <= 2'b10;
            end else if (upd_cnt != 2'b11) begin
                btb_cnt[upd_idx] <= upd_cnt + 2'd1;
            end
        end else if (is_branch_rob && upd_hit && upd_cnt != 2'b00) begin
            btb_cnt[upd_idx] <= upd_cnt - 2'd1;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// slots per fetch group
`define FETCH_WIDTH 4

// lanes towards the decoder
`define DEC_WIDTH 3

// legal byte window of the instruction memory
// IMEM_MAX is the last byte of a 16-byte group
`define IMEM_MIN 32'h1c00_0000
`define IMEM_MAX 32'h1c00_ffff

`define BTB_DEPTH 16
`define IFIFO_DEPTH 16

// fetch address error
`define ADEF 5'd8

`endif

// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    typedef logic [4:0] excp_code_t;

    // 2'b00 strongly not taken up to 2'b11 strongly taken
    typedef logic [1:0] counter_t;

endpackage

`default_nettype wire

// File: logic/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module inst_fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_pc_branch,
    input  logic                  flush_pc_excp,
    input  logic                  flush_pc_ertn,
    input  logic                  stall_pc,
    input  logic                  flush_ififo,
    input  logic                  stall_ififo,
    output logic                  jump,
    output logic                  miss,
    output logic                  full_ififo,
    output logic                  ready_pc_out      [`DEC_WIDTH],
    output fetch_pkg::addr_t      pc_out            [`DEC_WIDTH],
    output fetch_pkg::inst_t      inst_out          [`DEC_WIDTH],
    output logic                  is_branch_out     [`DEC_WIDTH],
    output logic                  predict_out       [`DEC_WIDTH],
    output fetch_pkg::addr_t      target_branch_out [`DEC_WIDTH],
    output logic                  has_excp_out      [`DEC_WIDTH],
    output fetch_pkg::excp_code_t excp_code_out     [`DEC_WIDTH],
    input  logic                  is_branch_rob,
    input  logic                  branch_rob,
    input  fetch_pkg::addr_t      target_rob,
    input  fetch_pkg::addr_t      pc_rob,
    input  fetch_pkg::addr_t      target_excp,
    input  fetch_pkg::addr_t      target_ertn,
    output logic                  mem_rd_imem,
    output fetch_pkg::addr_t      pc_imem,
    input  fetch_pkg::inst_t      inst              [`FETCH_WIDTH],
    input  logic                  find_inst         [`FETCH_WIDTH]
);

    fetch_pkg::addr_t pc;
    fetch_pkg::addr_t slot_pc [`FETCH_WIDTH];
    logic             slot_live [`FETCH_WIDTH];
    logic             addr_excp;
    logic             all_found;
    logic             fetch_ok;
    logic             capture;

    // predictor
    logic             hit [`FETCH_WIDTH];
    logic             predict [`FETCH_WIDTH];
    fetch_pkg::addr_t target_branch [`FETCH_WIDTH];
    fetch_pkg::addr_t target_first;
    logic             predict_any;

    // fetch register
    logic             fr_valid [`FETCH_WIDTH];
    fetch_pkg::addr_t fr_pc [`FETCH_WIDTH];
    fetch_pkg::inst_t fr_inst [`FETCH_WIDTH];
    logic             fr_predict [`FETCH_WIDTH];
    fetch_pkg::addr_t fr_target [`FETCH_WIDTH];
    logic             fr_excp;

    // predecoder
    logic                  valid_inst [`FETCH_WIDTH];
    logic                  is_branch [`FETCH_WIDTH];
    logic                  pd_predict [`FETCH_WIDTH];
    fetch_pkg::addr_t      pd_target [`FETCH_WIDTH];
    fetch_pkg::addr_t      target_jump;
    fetch_pkg::addr_t      pc_miss;
    logic                  has_excp [`FETCH_WIDTH];
    fetch_pkg::excp_code_t excp_code [`FETCH_WIDTH];

    assign addr_excp   = pc < `IMEM_MIN || pc > `IMEM_MAX || pc[1:0] != 2'b00;
    assign mem_rd_imem = !addr_excp;
    assign pc_imem     = pc;

    // live slots start at the base word and stop after a taken prediction
    always_comb begin
        logic taken_seen;
        taken_seen = 1'b0;
        all_found  = 1'b1;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slot_pc[i]   = {pc[31:4], 2'(i), 2'b00};
            slot_live[i] = 2'(i) >= pc[3:2] && !taken_seen;
            if (slot_live[i] && hit[i] && predict[i]) begin
                taken_seen = 1'b1;
            end
            if (slot_live[i] && !find_inst[i]) begin
                all_found = 1'b0;
            end
        end
    end

    // a faulting fetch needs nothing from memory
    assign fetch_ok = addr_excp || all_found;
    assign capture  = fetch_ok && !stall_pc && !full_ififo && !flush_pc_excp
                      && !flush_pc_ertn && !flush_pc_branch && !jump && !miss;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            fr_pc[i]      <= (addr_excp && i == 0) ? pc : slot_pc[i];
            fr_inst[i]    <= addr_excp ? '0 : inst[i];
            fr_predict[i] <= !addr_excp && slot_live[i] && hit[i] && predict[i];
            fr_target[i]  <= target_branch[i];
        end
        if (rst) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                fr_valid[i] <= 1'b0;
            end
            fr_excp <= 1'b0;
        end else begin
            // slot 0 travels alone on an address fault
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                fr_valid[i] <= capture && (addr_excp ? i == 0 : slot_live[i]);
            end
            fr_excp <= capture && addr_excp;
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            has_excp[i]  = fr_excp;
            excp_code[i] = fr_excp ? `ADEF : 5'd0;
        end
    end

    pc_gen u_pc_gen (
        .clk             (clk),
        .rst             (rst),
        .flush_pc_branch (flush_pc_branch),
        .flush_pc_excp   (flush_pc_excp),
        .flush_pc_ertn   (flush_pc_ertn),
        .stall_pc        (stall_pc),
        .full_ififo      (full_ififo),
        .fetch_ok        (fetch_ok),
        .target_rob      (target_rob),
        .target_excp     (target_excp),
        .target_ertn     (target_ertn),
        .target_jump     (target_jump),
        .pc_miss         (pc_miss),
        .target_branch   (target_first),
        .jump            (jump),
        .miss            (miss),
        .predict         (predict_any),
        .pc              (pc)
    );

    branch_predictor u_branch_predictor (
        .clk           (clk),
        .rst           (rst),
        .pc            (pc),
        .hit           (hit),
        .predict       (predict),
        .target_branch (target_branch),
        .target_first  (target_first),
        .predict_any   (predict_any),
        .is_branch_rob (is_branch_rob),
        .branch_rob    (branch_rob),
        .pc_rob        (pc_rob),
        .target_rob    (target_rob)
    );

    predecoder u_predecoder (
        .pc             (fr_pc),
        .inst           (fr_inst),
        .slot_valid     (fr_valid),
        .predict        (fr_predict),
        .target_predict (fr_target),
        .valid_inst     (valid_inst),
        .is_branch      (is_branch),
        .predict_out    (pd_predict),
        .target_out     (pd_target),
        .jump           (jump),
        .miss           (miss),
        .target_jump    (target_jump),
        .pc_miss        (pc_miss)
    );

    inst_fifo u_inst_fifo (
        .clk               (clk),
        .rst               (rst),
        .flush_ififo       (flush_ififo),
        .stall_ififo       (stall_ififo),
        .pc                (fr_pc),
        .inst              (fr_inst),
        .valid_inst        (valid_inst),
        .is_branch         (is_branch),
        .predict           (pd_predict),
        .has_excp          (has_excp),
        .target_branch     (pd_target),
        .excp_code         (excp_code),
        .full_ififo        (full_ififo),
        .ready_pc_out      (ready_pc_out),
        .is_branch_out     (is_branch_out),
        .predict_out       (predict_out),
        .has_excp_out      (has_excp_out),
        .pc_out            (pc_out),
        .target_branch_out (target_branch_out),
        .inst_out          (inst_out),
        .excp_code_out     (excp_code_out)
    );

endmodule

`default_nettype wire

// File: logic/inst_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module inst_fifo (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_ififo,
    input  logic                  stall_ififo,
    input  fetch_pkg::addr_t      pc                [`FETCH_WIDTH],
    input  fetch_pkg::inst_t      inst              [`FETCH_WIDTH],
    input  logic                  valid_inst        [`FETCH_WIDTH],
    input  logic                  is_branch         [`FETCH_WIDTH],
    input  logic                  predict           [`FETCH_WIDTH],
    input  logic                  has_excp          [`FETCH_WIDTH],
    input  fetch_pkg::addr_t      target_branch     [`FETCH_WIDTH],
    input  fetch_pkg::excp_code_t excp_code         [`FETCH_WIDTH],
    output logic                  full_ififo,
    output logic                  ready_pc_out      [`DEC_WIDTH],
    output logic                  is_branch_out     [`DEC_WIDTH],
    output logic                  predict_out       [`DEC_WIDTH],
    output logic                  has_excp_out      [`DEC_WIDTH],
    output fetch_pkg::addr_t      pc_out            [`DEC_WIDTH],
    output fetch_pkg::addr_t      target_branch_out [`DEC_WIDTH],
    output fetch_pkg::inst_t      inst_out          [`DEC_WIDTH],
    output fetch_pkg::excp_code_t excp_code_out     [`DEC_WIDTH]
);

    localparam int PTR_W = $clog2(`IFIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [2:0]       wr_num;
    logic [1:0]       rd_num;
    logic [PTR_W-1:0] wr_addr [`FETCH_WIDTH];

    fetch_pkg::addr_t      q_pc     [`IFIFO_DEPTH];
    fetch_pkg::inst_t      q_inst   [`IFIFO_DEPTH];
    logic                  q_br     [`IFIFO_DEPTH];
    logic                  q_pred   [`IFIFO_DEPTH];
    logic                  q_excp   [`IFIFO_DEPTH];
    fetch_pkg::addr_t      q_target [`IFIFO_DEPTH];
    fetch_pkg::excp_code_t q_code   [`IFIFO_DEPTH];

    // valid slots pack into consecutive entries
    always_comb begin
        wr_num = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            wr_addr[i] = tail + PTR_W'(wr_num);
            wr_num     = wr_num + {2'b00, valid_inst[i]};
        end
    end

    assign rd_num = stall_ififo ? 2'd0 :
                    (count > CNT_W'(`DEC_WIDTH) ? 2'(`DEC_WIDTH) : count[1:0]);

    // looks past this cycle's write so the group behind it still fits
    assign full_ififo = (count + CNT_W'(wr_num)) > CNT_W'(`IFIFO_DEPTH - `FETCH_WIDTH);

    always_ff @(posedge clk) begin
        if (rst || flush_ififo) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_W'(rd_num);
            tail  <= tail + PTR_W'(wr_num);
            count <= count + CNT_W'(wr_num) - CNT_W'(rd_num);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (valid_inst[i] && !flush_ififo) begin
                q_pc[wr_addr[i]]     <= pc[i];
                q_inst[wr_addr[i]]   <= inst[i];
                q_br[wr_addr[i]]     <= is_branch[i];
                q_pred[wr_addr[i]]   <= predict[i];
                q_excp[wr_addr[i]]   <= has_excp[i];
                q_target[wr_addr[i]] <= target_branch[i];
                q_code[wr_addr[i]]   <= excp_code[i];
            end
        end
    end

    always_comb begin
        logic [PTR_W-1:0] idx;
        for (int j = 0; j < `DEC_WIDTH; j++) begin
            idx                  = head + PTR_W'(j);
            ready_pc_out[j]      = count > CNT_W'(j);
            pc_out[j]            = q_pc[idx];
            inst_out[j]          = q_inst[idx];
            is_branch_out[j]     = q_br[idx];
            predict_out[j]       = q_pred[idx];
            has_excp_out[j]      = q_excp[idx];
            target_branch_out[j] = q_target[idx];
            excp_code_out[j]     = q_code[idx];
        end
    end

    // a full cycle keeps the next group out of the fetch register
    assert property (@(posedge clk) disable iff (rst) full_ififo |=> wr_num == 3'd0)
        else $error("instruction FIFO written after full_ififo");

endmodule

`default_nettype wire

// File: logic/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module pc_gen (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush_pc_branch,
    input  logic             flush_pc_excp,
    input  logic             flush_pc_ertn,
    input  logic             stall_pc,
    input  logic             full_ififo,
    input  logic             fetch_ok,
    input  fetch_pkg::addr_t target_rob,
    input  fetch_pkg::addr_t target_excp,
    input  fetch_pkg::addr_t target_ertn,
    input  fetch_pkg::addr_t target_jump,
    input  fetch_pkg::addr_t pc_miss,
    input  fetch_pkg::addr_t target_branch,
    input  logic             jump,
    input  logic             miss,
    input  logic             predict,
    output fetch_pkg::addr_t pc
);

    fetch_pkg::addr_t pc_next;

    always_comb begin
        if (flush_pc_excp) begin
            pc_next = target_excp;
        end else if (flush_pc_ertn) begin
            pc_next = target_ertn;
        end else if (flush_pc_branch) begin
            pc_next = target_rob;
        end else if (jump) begin
            pc_next = target_jump;
        end else if (miss) begin
            pc_next = pc_miss;
        end else if (stall_pc || full_ififo || !fetch_ok) begin
            pc_next = pc;
        end else if (predict) begin
            pc_next = target_branch;
        end else begin
            // next 16-byte group
            pc_next = {pc[31:4] + 28'd1, 4'b0000};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `IMEM_MIN;
        end else begin
            pc <= pc_next;
        end
    end

    // predictor and predecoder targets keep an aligned pc aligned
    assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00 && !(flush_pc_excp || flush_pc_ertn || flush_pc_branch)
        |=> pc[1:0] == 2'b00)
        else $error("pc lost word alignment without a flush");

endmodule

`default_nettype wire

// File: logic/predecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module predecoder (
    input  fetch_pkg::addr_t pc             [`FETCH_WIDTH],
    input  fetch_pkg::inst_t inst           [`FETCH_WIDTH],
    input  logic             slot_valid     [`FETCH_WIDTH],
    input  logic             predict        [`FETCH_WIDTH],
    input  fetch_pkg::addr_t target_predict [`FETCH_WIDTH],
    output logic             valid_inst     [`FETCH_WIDTH],
    output logic             is_branch      [`FETCH_WIDTH],
    output logic             predict_out    [`FETCH_WIDTH],
    output fetch_pkg::addr_t target_out     [`FETCH_WIDTH],
    output logic             jump,
    output logic             miss,
    output fetch_pkg::addr_t target_jump,
    output fetch_pkg::addr_t pc_miss
);

    // only the oldest offending slot redirects
    always_comb begin
        logic             done;
        logic             is_b;
        logic [5:0]       opcode;
        logic [25:0]      offs;
        fetch_pkg::addr_t b_target;
        done        = 1'b0;
        jump        = 1'b0;
        miss        = 1'b0;
        target_jump = '0;
        pc_miss     = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            opcode = inst[i][31:26];
            // offs[15:0] sits in [25:10], offs[25:16] in [9:0]
            offs     = {inst[i][9:0], inst[i][25:10]};
            b_target = pc[i] + {{4{offs[25]}}, offs, 2'b00};
            is_b     = opcode == 6'h14 || opcode == 6'h15;

            is_branch[i]   = slot_valid[i] && opcode >= 6'h14 && opcode <= 6'h1b;
            valid_inst[i]  = slot_valid[i] && !done;
            predict_out[i] = predict[i] && valid_inst[i];
            target_out[i]  = is_b ? b_target : target_predict[i];

            if (valid_inst[i]) begin
                if (is_b && !predict[i]) begin
                    // unconditional and not predicted, later slots are dead
                    jump        = 1'b1;
                    target_jump = b_target;
                    done        = 1'b1;
                end else if (predict[i] && !is_branch[i]) begin
                    miss           = 1'b1;
                    pc_miss        = pc[i] + 32'd4;
                    predict_out[i] = 1'b0;
                    done           = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire
